// ==== hw/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'hbfc00000

// data and address width
`define CORE_XLEN 32

// register file geometry
`define CORE_NREGS 32
`define CORE_RADDR_W 5

`endif

// ==== hw/core_pkg.sv ====
`default_nettype none

`include "core_params.svh"

package core_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} alu_op_t;

	// fetch to decode
	typedef struct packed {
		logic                  valid;
		logic [`CORE_XLEN-1:0] pc;
		logic [`CORE_XLEN-1:0] inst;
	} fetch_pkt_t;

	// decode to execute, operands already resolved
	typedef struct packed {
		logic                     valid;
		logic [`CORE_XLEN-1:0]    pc;
		alu_op_t                  alu_op;
		logic [`CORE_XLEN-1:0]    op_a;
		logic [`CORE_XLEN-1:0]    op_b;
		logic                     wen;
		logic [`CORE_RADDR_W-1:0] rd;
	} exec_pkt_t;

	// execute to write-back
	typedef struct packed {
		logic                     valid;
		logic [`CORE_XLEN-1:0]    pc;
		logic                     wen;
		logic [`CORE_RADDR_W-1:0] rd;
		logic [`CORE_XLEN-1:0]    result;
	} wb_pkt_t;

endpackage

`default_nettype wire

// ==== hw/inst_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module inst_fetch (
	input  wire logic                  clk,
	input  wire logic                  resetn,
	output logic                       inst_req,
	output logic [`CORE_XLEN-1:0]      inst_addr,
	input  wire logic                  inst_addr_ok,
	input  wire logic                  inst_data_ok,
	input  wire logic [`CORE_XLEN-1:0] inst_rdata,
	output core_pkg::fetch_pkt_t       fetch
);

	logic [`CORE_XLEN-1:0] pc;
	logic [`CORE_XLEN-1:0] req_pc;
	logic                  started;
	logic                  outstanding;
	logic                  accepted;

	// one request in flight at most
	assign inst_req  = started && !outstanding;
	assign inst_addr = pc;
	assign accepted  = inst_req && inst_addr_ok;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			pc          <= `CORE_RESET_PC;
			started     <= 1'b0;
			outstanding <= 1'b0;
		end
		else
		begin
			// holds the request off for the first cycle after reset
			started <= 1'b1;
			if (accepted)
			begin
				pc          <= pc + `CORE_XLEN'(4);
				outstanding <= 1'b1;
			end
			else if (inst_data_ok)
				outstanding <= 1'b0;
		end
	end

	// pc of the request still waiting for its word
	always_ff @(posedge clk)
	begin
		if (accepted)
			req_pc <= pc;
	end

	always_ff @(posedge clk)
	begin
		if (inst_data_ok)
		begin
			fetch.pc   <= req_pc;
			fetch.inst <= inst_rdata;
		end
		fetch.valid <= inst_data_ok;
		if (!resetn)
			fetch.valid <= 1'b0;
	end

	a_data_needs_request: assert property (
		@(posedge clk) disable iff (!resetn)
		inst_data_ok |-> outstanding
	);

endmodule

`default_nettype wire

// ==== hw/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module inst_decode (
	input  wire logic                     clk,
	input  wire logic                     resetn,
	input  wire core_pkg::fetch_pkt_t     fetch,
	output logic [`CORE_RADDR_W-1:0]      rs_addr,
	output logic [`CORE_RADDR_W-1:0]      rt_addr,
	input  wire logic [`CORE_XLEN-1:0]    rs_data,
	input  wire logic [`CORE_XLEN-1:0]    rt_data,
	input  wire logic                     ex_fwd_en,
	input  wire logic [`CORE_RADDR_W-1:0] ex_fwd_addr,
	input  wire logic [`CORE_XLEN-1:0]    ex_fwd_data,
	input  wire core_pkg::wb_pkt_t        wb,
	output core_pkg::exec_pkt_t           exec
);

	import core_pkg::*;

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	logic [5:0]               opcode;
	logic [5:0]               funct;
	logic [4:0]               shamt;
	logic [15:0]              imm;
	logic [`CORE_RADDR_W-1:0] rd;
	logic [`CORE_XLEN-1:0]    rs_val;
	logic [`CORE_XLEN-1:0]    rt_val;
	exec_pkt_t                next;

	assign opcode  = fetch.inst[31:26];
	assign rs_addr = fetch.inst[25:21];
	assign rt_addr = fetch.inst[20:16];
	assign rd      = fetch.inst[15:11];
	assign shamt   = fetch.inst[10:6];
	assign funct   = fetch.inst[5:0];
	assign imm     = fetch.inst[15:0];

	// execute result first, then write-back, then the register file
	function automatic logic [`CORE_XLEN-1:0] operand(
		input logic [`CORE_RADDR_W-1:0] addr,
		input logic [`CORE_XLEN-1:0]    rf_data
	);
		if (ex_fwd_en && ex_fwd_addr == addr && addr != '0)
			return ex_fwd_data;
		if (wb.valid && wb.wen && wb.rd == addr && addr != '0)
			return wb.result;
		return rf_data;
	endfunction

	always_comb
	begin
		rs_val = operand(rs_addr, rs_data);
		rt_val = operand(rt_addr, rt_data);
	end

	always_comb
	begin
		next.valid  = fetch.valid;
		next.pc     = fetch.pc;
		next.alu_op = ALU_ADD;
		next.op_a   = rs_val;
		next.op_b   = rt_val;
		next.wen    = 1'b0;
		next.rd     = rd;
		case (opcode)
			OP_SPECIAL:
			begin
				next.wen = 1'b1;
				case (funct)
					6'h21: next.alu_op = ALU_ADD;
					6'h23: next.alu_op = ALU_SUB;
					6'h24: next.alu_op = ALU_AND;
					6'h25: next.alu_op = ALU_OR;
					6'h26: next.alu_op = ALU_XOR;
					6'h2a: next.alu_op = ALU_SLT;
					6'h00:
					begin
						next.alu_op = ALU_SLL;
						next.op_a   = {{(`CORE_XLEN-5){1'b0}}, shamt};
					end
					default: next.wen = 1'b0;
				endcase
			end
			OP_ADDIU:
			begin
				next.op_b = {{(`CORE_XLEN-16){imm[15]}}, imm};
				next.wen  = 1'b1;
				next.rd   = rt_addr;
			end
			OP_ORI, OP_LUI:
			begin
				next.alu_op = (opcode == OP_LUI) ? ALU_LUI : ALU_OR;
				next.op_b   = {{(`CORE_XLEN-16){1'b0}}, imm};
				next.wen    = 1'b1;
				next.rd     = rt_addr;
			end
			// unknown encodings pass through as a bubble that writes nothing
			default: next.wen = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		exec <= next;
		if (!resetn)
			exec.valid <= 1'b0;
	end

	a_exec_follows_fetch: assert property (
		@(posedge clk) disable iff (!resetn)
		fetch.valid |=> exec.valid
	);

endmodule

`default_nettype wire

// ==== hw/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module alu_execute (
	input  wire logic                 clk,
	input  wire logic                 resetn,
	input  wire core_pkg::exec_pkt_t  exec,
	output logic                      fwd_en,
	output logic [`CORE_RADDR_W-1:0]  fwd_addr,
	output logic [`CORE_XLEN-1:0]     fwd_data,
	output core_pkg::wb_pkt_t         wb
);

	import core_pkg::*;

	logic [`CORE_XLEN-1:0] result;

	always_comb
	begin
		case (exec.alu_op)
			ALU_ADD: result = exec.op_a + exec.op_b;
			ALU_SUB: result = exec.op_a - exec.op_b;
			ALU_AND: result = exec.op_a & exec.op_b;
			ALU_OR:  result = exec.op_a | exec.op_b;
			ALU_XOR: result = exec.op_a ^ exec.op_b;
			ALU_SLT: result = {{(`CORE_XLEN-1){1'b0}}, $signed(exec.op_a) < $signed(exec.op_b)};
			// shift amount sits in op_a
			ALU_SLL: result = exec.op_b << exec.op_a[4:0];
			ALU_LUI: result = {exec.op_b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	// bypass into decode
	assign fwd_en   = exec.valid && exec.wen;
	assign fwd_addr = exec.rd;
	assign fwd_data = result;

	always_ff @(posedge clk)
	begin
		wb.valid  <= exec.valid;
		wb.pc     <= exec.pc;
		wb.wen    <= exec.wen;
		wb.rd     <= exec.rd;
		wb.result <= result;
		if (!resetn)
			wb.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module reg_file (
	input  wire logic                     clk,
	input  wire logic                     resetn,
	input  wire logic [`CORE_RADDR_W-1:0] raddr1,
	input  wire logic [`CORE_RADDR_W-1:0] raddr2,
	output logic [`CORE_XLEN-1:0]         rdata1,
	output logic [`CORE_XLEN-1:0]         rdata2,
	input  wire core_pkg::wb_pkt_t        wb
);

	logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
	logic                  wr_en;

	assign wr_en = wb.valid && wb.wen && wb.rd != '0;

	always_ff @(posedge clk)
	begin
		if (!resetn)
			regs <= '{default: '0};
		else if (wr_en)
			regs[wb.rd] <= wb.result;
	end

	// r0 reads as zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	a_r0_stays_zero: assert property (
		@(posedge clk) disable iff (!resetn)
		wb.valid && wb.wen && wb.rd == '0 |=> regs[0] == '0
	);

endmodule

`default_nettype wire

// ==== hw/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module cpu_core (
	input  wire logic                  clk,
	input  wire logic                  resetn,
	output logic                       inst_req,
	output logic                       inst_wr,
	output logic [1:0]                 inst_size,
	output logic [`CORE_XLEN-1:0]      inst_addr,
	output logic [`CORE_XLEN-1:0]      inst_wdata,
	input  wire logic                  inst_addr_ok,
	input  wire logic                  inst_data_ok,
	input  wire logic [`CORE_XLEN-1:0] inst_rdata,
	output logic [`CORE_XLEN-1:0]      debug_wb_pc,
	output logic [3:0]                 debug_wb_rf_wen,
	output logic [4:0]                 debug_wb_rf_wnum,
	output logic [`CORE_XLEN-1:0]      debug_wb_rf_wdata
);

	import core_pkg::*;

	fetch_pkt_t               fetch_pkt;
	exec_pkt_t                exec_pkt;
	wb_pkt_t                  wb_pkt;
	logic [`CORE_RADDR_W-1:0] rs_addr;
	logic [`CORE_RADDR_W-1:0] rt_addr;
	logic [`CORE_XLEN-1:0]    rs_data;
	logic [`CORE_XLEN-1:0]    rt_data;
	logic                     ex_fwd_en;
	logic [`CORE_RADDR_W-1:0] ex_fwd_addr;
	logic [`CORE_XLEN-1:0]    ex_fwd_data;

	// read-only word fetches
	assign inst_wr    = 1'b0;
	assign inst_size  = 2'd2;
	assign inst_wdata = '0;

	inst_fetch u_fetch (
		.clk          (clk         ),
		.resetn       (resetn      ),
		.inst_req     (inst_req    ),
		.inst_addr    (inst_addr   ),
		.inst_addr_ok (inst_addr_ok),
		.inst_data_ok (inst_data_ok),
		.inst_rdata   (inst_rdata  ),
		.fetch        (fetch_pkt   )
	);

	inst_decode u_decode (
		.clk         (clk        ),
		.resetn      (resetn     ),
		.fetch       (fetch_pkt  ),
		.rs_addr     (rs_addr    ),
		.rt_addr     (rt_addr    ),
		.rs_data     (rs_data    ),
		.rt_data     (rt_data    ),
		.ex_fwd_en   (ex_fwd_en  ),
		.ex_fwd_addr (ex_fwd_addr),
		.ex_fwd_data (ex_fwd_data),
		.wb          (wb_pkt     ),
		.exec        (exec_pkt   )
	);

	alu_execute u_execute (
		.clk      (clk        ),
		.resetn   (resetn     ),
		.exec     (exec_pkt   ),
		.fwd_en   (ex_fwd_en  ),
		.fwd_addr (ex_fwd_addr),
		.fwd_data (ex_fwd_data),
		.wb       (wb_pkt     )
	);

	reg_file u_regs (
		.clk    (clk    ),
		.resetn (resetn ),
		.raddr1 (rs_addr),
		.raddr2 (rt_addr),
		.rdata1 (rs_data),
		.rdata2 (rt_data),
		.wb     (wb_pkt )
	);

	// trace shows only writes that land in the register file
	assign debug_wb_pc       = wb_pkt.pc;
	assign debug_wb_rf_wen   = {4{wb_pkt.valid && wb_pkt.wen && wb_pkt.rd != '0}};
	assign debug_wb_rf_wnum  = wb_pkt.rd;
	assign debug_wb_rf_wdata = wb_pkt.result;

endmodule

`default_nettype wire

// ==== testbench/tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module tb_cpu_core;

	import core_pkg::*;

	logic                  clk;
	logic                  resetn;
	logic                  inst_req;
	logic                  inst_wr;
	logic [1:0]            inst_size;
	logic [`CORE_XLEN-1:0] inst_addr;
	logic [`CORE_XLEN-1:0] inst_wdata;
	logic                  inst_addr_ok;
	logic                  inst_data_ok;
	logic [`CORE_XLEN-1:0] inst_rdata;
	logic [`CORE_XLEN-1:0] debug_wb_pc;
	logic [3:0]            debug_wb_rf_wen;
	logic [4:0]            debug_wb_rf_wnum;
	logic [`CORE_XLEN-1:0] debug_wb_rf_wdata;

	// two header words, program words, then four words per trace entry
	logic [31:0]           file_words [0:255];
	int                    n_words;
	int                    n_trace;
	int                    trace_idx;
	integer                seed;
	logic [`CORE_XLEN-1:0] data_pc;
	int                    checks [1:6];
	int                    errors [1:6];
	int                    ok_cycle [$];
	logic [`CORE_XLEN-1:0] ok_pc [$];

	cpu_core dut (
		.clk               (clk              ),
		.resetn            (resetn           ),
		.inst_req          (inst_req         ),
		.inst_wr           (inst_wr          ),
		.inst_size         (inst_size        ),
		.inst_addr         (inst_addr        ),
		.inst_wdata        (inst_wdata       ),
		.inst_addr_ok      (inst_addr_ok     ),
		.inst_data_ok      (inst_data_ok     ),
		.inst_rdata        (inst_rdata       ),
		.debug_wb_pc       (debug_wb_pc      ),
		.debug_wb_rf_wen   (debug_wb_rf_wen  ),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum ),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

	function automatic int random_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] program_word(input logic [`CORE_XLEN-1:0] addr);
		logic [`CORE_XLEN-1:0] index;
		index = (addr - `CORE_RESET_PC) >> 2;
		if (index < n_words)
			return file_words[2 + index];
		// sll r0, r0, 0 writes nothing
		return 32'h0000_0000;
	endfunction

	function automatic string behavior_name(input int i);
		case (i)
			1: return "reset and first fetch";
			2: return "fetch address sequence";
			3: return "trace values";
			4: return "dependent instructions";
			5: return "register zero";
			default: return "write-back latency";
		endcase
	endfunction

	task automatic check_word(input int which, input string sig,
		input logic [`CORE_XLEN-1:0] actual, input logic [`CORE_XLEN-1:0] expected);
		checks[which]++;
		if (actual !== expected)
		begin
			errors[which]++;
			$display("Error: %s = %h, expected %h", sig, actual, expected);
		end
	endtask

	task automatic check_reg(input int which, input string sig,
		input logic [`CORE_RADDR_W-1:0] actual, input logic [`CORE_RADDR_W-1:0] expected);
		checks[which]++;
		if (actual !== expected)
		begin
			errors[which]++;
			$display("Error: %s = %h, expected %h", sig, actual, expected);
		end
	endtask

	// every fetch is a plain word read
	task automatic check_request(input int which, input logic wr, input logic [1:0] size,
		input logic [`CORE_XLEN-1:0] wdata);
		checks[which]++;
		if (wr !== 1'b0 || size !== 2'd2 || wdata !== '0)
		begin
			errors[which]++;
			$display("Error: inst_wr = %h, inst_size = %h, inst_wdata = %h, expected 0, 2, 0",
				wr, size, wdata);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	// instruction memory with random handshake delays
	initial
	begin : memory_model
		int                    addr_wait;
		int                    data_wait;
		logic                  busy;
		logic                  accept;
		logic                  first;
		logic [`CORE_XLEN-1:0] last_addr;
		logic [`CORE_XLEN-1:0] pend_addr;
		seed         = 22;
		inst_addr_ok = 1'b0;
		inst_data_ok = 1'b0;
		inst_rdata   = '0;
		data_pc      = '0;
		busy         = 1'b0;
		accept       = 1'b0;
		first        = 1'b1;
		data_wait    = 0;
		last_addr    = '0;
		pend_addr    = '0;
		addr_wait    = random_below(4);
		forever
		begin
			@(posedge clk);
			#2;
			inst_data_ok = 1'b0;
			if (accept)
			begin
				busy         = 1'b1;
				data_wait    = 1 + random_below(3);
				inst_addr_ok = 1'b0;
			end
			if (busy)
			begin
				data_wait--;
				if (data_wait == 0)
				begin
					inst_data_ok = 1'b1;
					inst_rdata   = program_word(pend_addr);
					data_pc      = pend_addr;
					busy         = 1'b0;
					addr_wait    = random_below(4);
				end
			end
			else
			begin
				inst_addr_ok = (addr_wait == 0);
				if (addr_wait != 0)
					addr_wait--;
			end
			@(negedge clk);
			accept = resetn && inst_req === 1'b1 && inst_addr_ok;
			if (accept)
			begin
				if (first)
					check_word(1, "inst_addr", inst_addr, `CORE_RESET_PC);
				else
					check_word(2, "inst_addr", inst_addr, last_addr + 32'd4);
				check_request(2, inst_wr, inst_size, inst_wdata);
				first     = 1'b0;
				last_addr = inst_addr;
				pend_addr = inst_addr;
			end
		end
	end

	initial
	begin : trace_monitor
		int      cycle;
		int      after_reset;
		int      base;
		int      which;
		int      lag;
		wb_pkt_t seen;
		cycle       = 0;
		after_reset = 0;
		forever
		begin
			@(negedge clk);
			cycle++;
			if (!resetn || after_reset == 0)
			begin
				checks[1]++;
				if (inst_req !== 1'b0 || debug_wb_rf_wen !== 4'h0)
				begin
					errors[1]++;
					$display("Error: inst_req = %h, debug_wb_rf_wen = %h around reset, expected 0",
						inst_req, debug_wb_rf_wen);
				end
			end
			if (resetn)
				after_reset++;
			if (inst_data_ok)
			begin
				ok_cycle.push_back(cycle);
				ok_pc.push_back(data_pc);
			end
			seen.valid  = resetn && debug_wb_rf_wen !== 4'h0;
			seen.wen    = debug_wb_rf_wen === 4'hf;
			seen.pc     = debug_wb_pc;
			seen.rd     = debug_wb_rf_wnum;
			seen.result = debug_wb_rf_wdata;
			if (seen.valid)
			begin
				if (!seen.wen)
				begin
					errors[3]++;
					$display("Error: debug_wb_rf_wen = %h, expected f", debug_wb_rf_wen);
				end
				if (seen.rd == '0)
				begin
					errors[5]++;
					$display("register zero shows up as written at pc %h", seen.pc);
				end
				if (trace_idx >= n_trace)
				begin
					errors[3]++;
					$display("unexpected write to r%0d at pc %h after the last expected one",
						seen.rd, seen.pc);
				end
				else
				begin
					base  = 2 + n_words + 4 * trace_idx;
					// tag column picks the behavior this entry stands for
					which = (file_words[base + 3] == 3) ? 5 : (file_words[base + 3] != 0) ? 4 : 3;
					check_word(which, "debug_wb_pc", seen.pc, file_words[base]);
					check_reg(which, "debug_wb_rf_wnum", seen.rd, file_words[base + 1][4:0]);
					check_word(which, "debug_wb_rf_wdata", seen.result, file_words[base + 2]);
					trace_idx++;
				end
				// words that wrote nothing drop out here
				while (ok_pc.size() > 0 && ok_pc[0] != seen.pc)
				begin
					void'(ok_pc.pop_front());
					void'(ok_cycle.pop_front());
				end
				checks[6]++;
				if (ok_pc.size() == 0)
				begin
					errors[6]++;
					$display("write at pc %h has no instruction word returned for it", seen.pc);
				end
				else
				begin
					lag = cycle - ok_cycle.pop_front();
					void'(ok_pc.pop_front());
					if (lag != 3)
					begin
						errors[6]++;
						$display("write at pc %h came %0d cycles after its word, not 3",
							seen.pc, lag);
					end
				end
			end
		end
	end

	initial
	begin : watchdog
		wait (n_words > 0);
		repeat (n_words * 8 + 50) @(posedge clk);
		$display("timeout with %0d of %0d expected register writes seen", trace_idx, n_trace);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin : main
		int i;
		int total_checks;
		int total_errors;
		resetn = 1'b0;
		$readmemh("testbench/program_input.txt", file_words);
		n_words = file_words[0];
		n_trace = file_words[1];
		if (n_words <= 0 || n_trace <= 0)
		begin
			errors[3]++;
			$display("stimulus file is missing or holds no program");
		end
		else
		begin
			repeat (2) @(posedge clk);
			#2;
			resetn = 1'b1;
			wait (trace_idx == n_trace);
			// idle tail to catch stray writes
			repeat (20) @(posedge clk);
		end
		total_checks = 0;
		total_errors = 0;
		for (i = 1; i <= 6; i++)
		begin
			if (checks[i] == 0)
			begin
				errors[i]++;
				$display("behavior %0d ran no checks", i);
			end
			$display("behavior %0d, %s: %0d checks, %0d errors",
				i, behavior_name(i), checks[i], errors[i]);
			total_checks += checks[i];
			total_errors += errors[i];
		end
		$display("%0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/program_input.txt ====
// header: program word count, trace entry count
// trace columns: pc, register, value, tag (0 plain, 1 uses previous result, 2 two back, 3 reads r0)
00000010
0000000e
3c011234 // lui   $1, 0x1234
34215678 // ori   $1, $1, 0x5678
2402fffd // addiu $2, $0, -3
00221821 // addu  $3, $1, $2
00412023 // subu  $4, $2, $1
00642824 // and   $5, $3, $4
00643025 // or    $6, $3, $4
00a63826 // xor   $7, $5, $6
0045402a // slt   $8, $2, $5
00a2482a // slt   $9, $5, $2
00015100 // sll   $10, $1, 4
2420007f // addiu $0, $1, 0x7f
000a5821 // addu  $11, $0, $10
340cbeef // ori   $12, $0, 0xbeef
00000000 // nop
256d8001 // addiu $13, $11, -0x7fff
bfc00000 01 12340000 0
bfc00004 01 12345678 1
bfc00008 02 fffffffd 0
bfc0000c 03 12345675 1
bfc00010 04 edcba985 2
bfc00014 05 00000005 1
bfc00018 06 fffffff5 2
bfc0001c 07 fffffff0 1
bfc00020 08 00000001 0
bfc00024 09 00000000 0
bfc00028 0a 23456780 0
bfc00030 0b 23456780 3
bfc00034 0c 0000beef 3
bfc0003c 0d 2344e781 0

// ==== verilog.f ====
+incdir+hw
hw/core_pkg.sv
hw/inst_fetch.sv
hw/inst_decode.sv
hw/alu_execute.sv
hw/reg_file.sv
hw/cpu_core.sv
testbench/tb_cpu_core.sv

// ==== Bender.yml ====
package:
  name: cpu_core

export_include_dirs:
  - hw

sources:
  - hw/core_pkg.sv
  - hw/inst_fetch.sv
  - hw/inst_decode.sv
  - hw/alu_execute.sv
  - hw/reg_file.sv
  - hw/cpu_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_cpu_core.sv
